// ==== common/fetch_pkg.sv ====
package fetch_pkg;

    localparam int xlen = 32;
    localparam logic [xlen-1:0] reset_pc = 32'h8000_0000;

    // class of a fetched word, as far as fetch needs to know
    typedef enum logic [2:0] {
        plain,
        jal,
        jalr,
        load,
        mul,
        div
    } inst_class_t;

    // instruction memory request, one strobe per fetch
    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] addr;
    } fetch_req_t;

    // instruction memory response
    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] data;
    } fetch_rsp_t;

    // decode result handed to the pc register
    typedef struct packed {
        inst_class_t     cls;
        logic [xlen-1:0] target;
        logic            redirect;
        logic            hold_jalr;
    } pc_ctrl_t;

endpackage

// ==== fetch/pc_gen.sv ====
module pc_gen
    import fetch_pkg::*;
#(
    parameter logic [xlen-1:0] reset_pc = fetch_pkg::reset_pc
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            fetch_done,
    input  pc_ctrl_t        ctrl,
    input  logic            mul_done,
    input  logic            div_done,
    output logic            fetch_en,
    output logic [xlen-1:0] pc
);

    logic            load_held;
    logic [xlen-1:0] pc_plus4;

    assign pc_plus4 = pc + xlen'(4);

    // fetch starts one cycle after reset release
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fetch_en <= 1'b0;
        end else begin
            fetch_en <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc        <= reset_pc;
            load_held <= 1'b0;
        end else if (fetch_done) begin
            // the refetched load word must not hold a second time
            load_held <= (ctrl.cls == load) && !load_held;

            if (ctrl.cls == mul) begin
                if (mul_done) begin
                    pc <= pc_plus4;
                end
            end else if (ctrl.cls == div) begin
                if (div_done) begin
                    pc <= pc_plus4;
                end
            end else if (ctrl.cls == load && !load_held) begin
                pc <= pc;
            end else if (ctrl.hold_jalr) begin
                // wait one fetch for the jalr target
                pc <= pc;
            end else if (ctrl.redirect) begin
                pc <= ctrl.target;
            end else begin
                pc <= pc_plus4;
            end
        end
    end

    // every path into pc keeps it on a word boundary
    assert property (@(posedge clk) disable iff (!rst_n) pc[1:0] == 2'b00)
        else $error("pc_gen: misaligned pc %h", pc);

endmodule

// ==== fetch/imem_port.sv ====
module imem_port
    import fetch_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    input  logic            fetch_en,
    input  logic [xlen-1:0] pc,
    output fetch_req_t      imem_req,
    input  fetch_rsp_t      imem_rsp,
    output logic            fetch_done,
    output logic [xlen-1:0] rsp_word
);

    logic            busy;
    logic [xlen-1:0] last_word;

    // one request per fetch, never two outstanding
    always_comb begin
        imem_req.valid = fetch_en && !busy;
        imem_req.addr  = pc;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
        end else if (imem_req.valid) begin
            busy <= 1'b1;
        end else if (imem_rsp.valid) begin
            busy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (imem_rsp.valid) begin
            last_word <= imem_rsp.data;
        end
    end

    assign fetch_done = imem_rsp.valid;

    // decode sees the live word in the response cycle, else the last one
    assign rsp_word = imem_rsp.valid ? imem_rsp.data : last_word;

    // the memory only answers an outstanding request
    assert property (@(posedge clk) disable iff (!rst_n) imem_rsp.valid |-> busy)
        else $error("imem_port: response with no request outstanding");

endmodule

// ==== hw/next_pc_calc.sv ====
module next_pc_calc
    import fetch_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    input  logic            fetch_done,
    input  logic [xlen-1:0] rsp_word,
    input  logic [xlen-1:0] pc,
    input  logic [xlen-1:0] jalr_base,
    output pc_ctrl_t        ctrl
);

    localparam logic [6:0] op_jal  = 7'b1101111;
    localparam logic [6:0] op_jalr = 7'b1100111;
    localparam logic [6:0] op_load = 7'b0000011;
    localparam logic [6:0] op_reg  = 7'b0110011;
    localparam logic [6:0] f7_muldiv = 7'b0000001;

    inst_class_t     cls;
    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [xlen-1:0] j_imm;
    logic [xlen-1:0] i_imm;
    logic [xlen-1:0] jalr_sum;
    logic            jalr_pend;
    logic [xlen-1:0] jalr_tgt;

    assign opcode = rsp_word[6:0];
    assign funct3 = rsp_word[14:12];
    assign funct7 = rsp_word[31:25];

    assign j_imm = {{12{rsp_word[31]}}, rsp_word[19:12], rsp_word[20],
                    rsp_word[30:21], 1'b0};
    assign i_imm = {{20{rsp_word[31]}}, rsp_word[31:20]};

    assign jalr_sum = jalr_base + i_imm;

    always_comb begin
        cls = plain;
        if (opcode == op_jal) begin
            cls = jal;
        end else if (opcode == op_jalr) begin
            cls = jalr;
        end else if (opcode == op_load) begin
            cls = load;
        end else if (opcode == op_reg && funct7 == f7_muldiv) begin
            // funct3 0..3 are the multiplies, 4..7 the divides
            cls = funct3[2] ? div : mul;
        end
    end

    // remember a jalr so that its refetch takes the target
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            jalr_pend <= 1'b0;
        end else if (fetch_done) begin
            jalr_pend <= (cls == jalr) && !jalr_pend;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_done && cls == jalr && !jalr_pend) begin
            jalr_tgt <= {jalr_sum[xlen-1:1], 1'b0};
        end
    end

    always_comb begin
        ctrl.cls       = cls;
        ctrl.hold_jalr = (cls == jalr) && !jalr_pend;
        ctrl.redirect  = (cls == jal) || jalr_pend;
        ctrl.target    = jalr_pend ? jalr_tgt : pc + j_imm;
    end

endmodule

// ==== hw/muldiv_seq.sv ====
module muldiv_seq
    import fetch_pkg::*;
#(
    parameter int mul_cycles = 3,
    parameter int div_cycles = 8
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        start,
    input  inst_class_t cls,
    input  logic        fetch_done,
    output logic        mul_done,
    output logic        div_done
);

    localparam int max_cycles = (mul_cycles > div_cycles) ? mul_cycles : div_cycles;
    localparam int cnt_w = $clog2(max_cycles + 1);

    logic             busy;
    logic             is_div;
    logic [cnt_w-1:0] cnt;
    logic [cnt_w-1:0] load_val;
    logic             finish;
    logic             fin_div;

    assign load_val = (cls == div) ? cnt_w'(div_cycles) : cnt_w'(mul_cycles);

    // a one-cycle op finishes straight from start
    assign finish  = (start && load_val == cnt_w'(1)) || (busy && cnt == cnt_w'(1));
    assign fin_div = start ? (cls == div) : is_div;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            is_div   <= 1'b0;
            cnt      <= '0;
            mul_done <= 1'b0;
            div_done <= 1'b0;
        end else begin
            if (start) begin
                is_div <= (cls == div);
                cnt    <= load_val - cnt_w'(1);
                busy   <= load_val > cnt_w'(1);
            end else if (busy) begin
                cnt <= cnt - cnt_w'(1);
                if (cnt == cnt_w'(1)) begin
                    busy <= 1'b0;
                end
            end

            // done is a level until a fetch completion picks it up
            if (finish) begin
                mul_done <= !fin_div;
                div_done <= fin_div;
            end else if (fetch_done) begin
                mul_done <= 1'b0;
                div_done <= 1'b0;
            end
        end
    end

    // the top must wait for the previous result to be consumed
    assert property (@(posedge clk) disable iff (!rst_n)
        start |-> !busy && !mul_done && !div_done)
        else $error("muldiv_seq: start while unit not idle");

endmodule

// ==== hw/fetch_top.sv ====
module fetch_top
    import fetch_pkg::*;
#(
    parameter int              mul_cycles = 3,
    parameter int              div_cycles = 8,
    parameter logic [xlen-1:0] reset_pc   = fetch_pkg::reset_pc
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic [xlen-1:0] jalr_base,
    output fetch_req_t      imem_req,
    input  fetch_rsp_t      imem_rsp
);

    logic            fetch_en;
    logic [xlen-1:0] pc;
    logic            fetch_done;
    logic [xlen-1:0] rsp_word;
    pc_ctrl_t        ctrl;
    logic            mul_done;
    logic            div_done;
    logic            md_start;
    logic            md_active;

    // one start per mul/div word, refetches of it do not restart
    assign md_start = fetch_done && (ctrl.cls == mul || ctrl.cls == div) && !md_active;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            md_active <= 1'b0;
        end else if (md_start) begin
            md_active <= 1'b1;
        end else if (fetch_done && (mul_done || div_done)) begin
            md_active <= 1'b0;
        end
    end

    pc_gen #(
        .reset_pc(reset_pc)
    ) u_pc_gen (
        .clk       (clk),
        .rst_n     (rst_n),
        .fetch_done(fetch_done),
        .ctrl      (ctrl),
        .mul_done  (mul_done),
        .div_done  (div_done),
        .fetch_en  (fetch_en),
        .pc        (pc)
    );

    imem_port u_imem_port (
        .clk       (clk),
        .rst_n     (rst_n),
        .fetch_en  (fetch_en),
        .pc        (pc),
        .imem_req  (imem_req),
        .imem_rsp  (imem_rsp),
        .fetch_done(fetch_done),
        .rsp_word  (rsp_word)
    );

    next_pc_calc u_next_pc_calc (
        .clk       (clk),
        .rst_n     (rst_n),
        .fetch_done(fetch_done),
        .rsp_word  (rsp_word),
        .pc        (pc),
        .jalr_base (jalr_base),
        .ctrl      (ctrl)
    );

    muldiv_seq #(
        .mul_cycles(mul_cycles),
        .div_cycles(div_cycles)
    ) u_muldiv_seq (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (md_start),
        .cls       (ctrl.cls),
        .fetch_done(fetch_done),
        .mul_done  (mul_done),
        .div_done  (div_done)
    );

endmodule

// ==== bench/fetch_tb.sv ====
module fetch_tb
    import fetch_pkg::*;
();

    localparam int mul_lat = 3;
    localparam int div_lat = 8;
    localparam logic [xlen-1:0] boot_pc = 32'h8000_0000;
    localparam logic [xlen-1:0] nop_word = 32'h0000_0013;

    logic            clk;
    logic            rst_n;
    logic [xlen-1:0] jalr_base;
    fetch_req_t      imem_req;
    fetch_rsp_t      imem_rsp;

    // program image and the request addresses it must produce
    logic [xlen-1:0] prog_addr_q[$];
    logic [xlen-1:0] prog_word_q[$];
    logic [xlen-1:0] exp_addr_q[$];
    int              exp_lat_q[$];

    int              err_cnt;
    int              req_cnt;
    int              exp_idx;
    int              cyc;
    int              limit;
    logic            timed_out;

    // memory model state
    logic            pending;
    int              wait_cnt;
    logic [xlen-1:0] pend_addr;
    int              last_rsp_cyc;
    fetch_rsp_t      rsp_next;

    // mul/div refetch tracking
    logic            md_wait;
    logic            md_first_set;
    int              md_first;
    int              md_lat;
    logic [xlen-1:0] md_addr;

    fetch_top #(
        .mul_cycles(mul_lat),
        .div_cycles(div_lat),
        .reset_pc  (boot_pc)
    ) UUT (
        .clk      (clk),
        .rst_n    (rst_n),
        .jalr_base(jalr_base),
        .imem_req (imem_req),
        .imem_rsp (imem_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic add_word(input logic [xlen-1:0] addr, input logic [xlen-1:0] word);
        prog_addr_q.push_back(addr);
        prog_word_q.push_back(word);
    endtask

    task automatic add_expect(input logic [xlen-1:0] addr, input int lat);
        exp_addr_q.push_back(addr);
        exp_lat_q.push_back(lat);
    endtask

    function automatic logic [xlen-1:0] word_at(input logic [xlen-1:0] addr);
        logic [xlen-1:0] w;
        w = nop_word;
        for (int i = 0; i < prog_addr_q.size(); i++) begin
            if (prog_addr_q[i] == addr) begin
                w = prog_word_q[i];
            end
        end
        return w;
    endfunction

    task automatic load_program();
        add_word(32'h8000_0000, 32'h0010_8093);  // addi x1, x1, 1
        add_word(32'h8000_0004, 32'h0010_8093);
        add_word(32'h8000_0008, 32'h0100_00ef);  // jal x1, +16
        add_word(32'h8000_0018, 32'h0010_8093);
        add_word(32'h8000_001c, 32'h0001_2183);  // lw x3, 0(x2)
        add_word(32'h8000_0020, 32'h0201_00e7);  // jalr x1, 0x20(x2)
        add_word(32'h8000_0120, 32'h0273_02b3);  // mul x5, x6, x7
        add_word(32'h8000_0124, 32'h0010_8093);
        add_word(32'h8000_0128, 32'h0273_42b3);  // div x5, x6, x7
        add_word(32'h8000_012c, 32'h0273_32b3);  // mulhu x5, x6, x7
        add_word(32'h8000_0130, 32'h0273_72b3);  // remu x5, x6, x7
        add_word(32'h8000_0134, 32'h0001_2183);  // lw x3, 0(x2)
        add_word(32'h8000_0138, 32'hf01f_f06f);  // jal x0, -256
        add_word(32'h8000_0038, 32'h0010_8093);
        add_word(32'h8000_003c, 32'h0010_8093);
    endtask

    // a nonzero latency marks a mul/div word that repeats until its unit is done
    task automatic load_expected();
        add_expect(32'h8000_0000, 0);
        add_expect(32'h8000_0004, 0);
        add_expect(32'h8000_0008, 0);
        add_expect(32'h8000_0018, 0);
        add_expect(32'h8000_001c, 0);
        add_expect(32'h8000_001c, 0);
        add_expect(32'h8000_0020, 0);
        add_expect(32'h8000_0020, 0);
        // 0x8000_0101 + 0x20, bit 0 cleared
        add_expect(32'h8000_0120, mul_lat);
        add_expect(32'h8000_0124, 0);
        add_expect(32'h8000_0128, div_lat);
        add_expect(32'h8000_012c, mul_lat);
        add_expect(32'h8000_0130, div_lat);
        add_expect(32'h8000_0134, 0);
        add_expect(32'h8000_0134, 0);
        add_expect(32'h8000_0138, 0);
        add_expect(32'h8000_0038, 0);
        add_expect(32'h8000_003c, 0);
        add_expect(32'h8000_0040, 0);
    endtask

    task automatic check_request(input logic [xlen-1:0] addr);
        logic [xlen-1:0] want;
        want = '0;
        if (md_wait && md_first_set && last_rsp_cyc < md_first + md_lat) begin
            // previous fetch finished before the result was ready
            want = md_addr;
        end else begin
            md_wait = 1'b0;
            want = exp_addr_q[exp_idx];
            if (exp_lat_q[exp_idx] != 0) begin
                md_wait      = 1'b1;
                md_first_set = 1'b0;
                md_addr      = want;
                md_lat       = exp_lat_q[exp_idx];
            end
            exp_idx++;
        end
        req_cnt++;
        if (addr !== want) begin
            $display("Error at time %0t: imem_req.addr = %h, expected %h", $time, addr, want);
            err_cnt++;
        end
    endtask

    initial begin
        void'($urandom(32'hed70_ec94));
        rst_n        = 1'b0;
        jalr_base    = 32'h8000_0101;
        imem_rsp     = '0;
        err_cnt      = 0;
        req_cnt      = 0;
        exp_idx      = 0;
        cyc          = 0;
        timed_out    = 1'b0;
        pending      = 1'b0;
        wait_cnt     = 0;
        pend_addr    = '0;
        last_rsp_cyc = 0;
        md_wait      = 1'b0;
        md_first_set = 1'b0;
        md_first     = 0;
        md_lat       = 0;
        md_addr      = '0;
        load_program();
        load_expected();
        limit = 40 * exp_addr_q.size();

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        while (exp_idx < exp_addr_q.size() && !timed_out) begin
            @(negedge clk);
            cyc++;

            // the next request follows a response by one cycle
            if (imem_rsp.valid === 1'b1 && imem_req.valid !== 1'b1) begin
                $display("Error at time %0t: imem_req.valid = %b, expected 1",
                         $time, imem_req.valid);
                err_cnt++;
            end

            rsp_next = '0;
            if (pending) begin
                wait_cnt--;
                if (wait_cnt == 0) begin
                    rsp_next.valid = 1'b1;
                    rsp_next.data  = word_at(pend_addr);
                    pending        = 1'b0;
                    last_rsp_cyc   = cyc;
                    if (md_wait && !md_first_set) begin
                        md_first     = cyc;
                        md_first_set = 1'b1;
                    end
                end
            end
            imem_rsp = rsp_next;

            if (imem_req.valid === 1'b1) begin
                if (pending) begin
                    $display("Request at time %0t while the previous one is still open", $time);
                    err_cnt++;
                end
                check_request(imem_req.addr);
                pending   = 1'b1;
                pend_addr = imem_req.addr;
                wait_cnt  = int'($urandom % 32'd4) + 1;
            end

            if (cyc >= limit) begin
                $display("Timeout: %0d of %0d expected requests seen after %0d cycles",
                         exp_idx, exp_addr_q.size(), cyc);
                err_cnt++;
                timed_out = 1'b1;
            end
        end

        $display("%0d requests checked, %0d errors", req_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
common/fetch_pkg.sv
fetch/pc_gen.sv
fetch/imem_port.sv
hw/next_pc_calc.sv
hw/muldiv_seq.sv
hw/fetch_top.sv
bench/fetch_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the fetch testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --assert --top-module fetch_tb -Mdir "$build_dir" -f filelist.f
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

"./$build_dir/Vfetch_tb" > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^All tests passed$" "$log_file"; then
    exit 0
fi
echo "pass message not found in $log_file"
exit 1
